// File: compile.f
+incdir+include
hw/dac_pkg.sv
hw/dac_frame_if.sv
hw/cal_if.sv
hw/cal_store.sv
hw/dac_val_cal.sv
hw/spi_frame_tx.sv
hw/dac_seq_ctrl.sv
hw/dac_ctrl_top.sv
dv/dac_ctrl_chk.sv
dv/dac_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dac_ctrl_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+')
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/dac_ctrl_tb.sv
`default_nettype none

module dac_ctrl_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int LONG_LIMIT  = 1500; // DAC_WR with a 1000 cycle delay
  localparam int SHORT_LIMIT = 300;
  localparam int RUN_CYCLES  = LONG_LIMIT + 6 * SHORT_LIMIT + 8 * 120; // Tests plus resets

  logic        clk;
  logic        resetn;
  logic [31:0] cmd_word;
  logic        cmd_empty;
  wire         cmd_rd_en, n_cs, mosi, ldac;
  wire         bad_cmd, cmd_buf_underflow, cal_oob, dac_val_oob, delay_too_short;
  wire  [4:0]  flags = {bad_cmd, cmd_buf_underflow, cal_oob, dac_val_oob, delay_too_short};

  logic [31:0] cmd_q[$];    // Show-ahead buffer contents
  logic [31:0] staged[$];   // Words written by the tests, moved in on the next cycle
  logic [23:0] exp_q[$];    // Expected SPI frames
  logic        pop_seen;
  logic [23:0] shift;       // Frame being collected
  int          bit_cnt;
  int          frames_seen;
  int          ldac_cnt;
  int          frames_at_ldac;
  int          errors = 0;
  int          tests = 0;
  int          tests_failed = 0;
  int          err_before;
  logic [31:0] lfsr = 32'h4d38;

  dac_ctrl_top dut (.*);

  bind dac_ctrl_top dac_ctrl_chk chk (
    .clk    (clk),
    .resetn (resetn),
    .n_cs   (n_cs),
    .ldac   (ldac),
    .flags  ({bad_cmd, cmd_buf_underflow, cal_oob, dac_val_oob, delay_too_short})
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // Command buffer model
  //////////////////////////////

  always @(negedge clk) pop_seen = cmd_rd_en; // Pop lands on the next edge

  always @(posedge clk) begin
    #1;
    if (!resetn) begin
      cmd_q.delete();
      staged.delete();
    end else begin
      if (pop_seen) begin
        if (cmd_q.size() != 0) begin
          void'(cmd_q.pop_front());
        end else begin
          $display("cmd_rd_en pulsed with the command buffer empty at %0t", $time);
          errors++;
        end
      end
      while (staged.size() != 0) cmd_q.push_back(staged.pop_front());
    end
    cmd_empty = (cmd_q.size() == 0);
    cmd_word  = cmd_empty ? 32'h0 : cmd_q[0];
  end

  //////////////////////////////
  // Frame and LDAC monitor
  //////////////////////////////

  always @(negedge clk) begin
    if (!resetn) begin
      bit_cnt = 0;
    end else if (!n_cs) begin
      shift = {shift[22:0], mosi}; // MSB first
      bit_cnt++;
    end else if (bit_cnt != 0) begin
      if (flags == '0 && bit_cnt != 24) begin
        $display("Frame cut short after %0d bits at %0t", bit_cnt, $time);
        errors++;
      end else if (flags == '0 && exp_q.size() == 0) begin
        $display("Unexpected frame %h at %0t", shift, $time);
        errors++;
      end else if (flags == '0) begin
        assert (shift == exp_q[0]) else begin
          $display("CHECK FAILED t=%0t mosi frame got %h expected %h", $time, shift, exp_q[0]);
          errors++;
        end
        void'(exp_q.pop_front());
      end
      if (bit_cnt == 24) frames_seen++;
      bit_cnt = 0;
    end
    if (resetn && ldac) begin
      ldac_cnt++;
      frames_at_ldac = frames_seen;
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per returned bit
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[14:0], fb};
    end
    return r;
  endfunction

  // Keeps room for a calibration offset on both sides
  function automatic logic [15:0] pick_code();
    return 16'h2000 + (rand_bits(16) % 16'hc000);
  endfunction

  function automatic logic [31:0] make_cmd(input logic [2:0] op, input logic cont,
                                           input logic ld, input logic [24:0] low);
    return {op, 1'b0, cont, ld, 1'b0, low};
  endfunction

  function automatic logic [23:0] frame_of(input logic [2:0] ch, input logic [15:0] code);
    return {4'b0001, 1'b0, ch, code};
  endfunction

  function automatic bit cond_met(input int what);
    if (what < 5) return flags[what];
    if (what == 5) return ldac_cnt != 0;
    return frames_seen != 0 && exp_q.size() == 0;
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    #1 resetn = 1'b0;
    exp_q.delete();
    frames_seen = 0;
    ldac_cnt    = 0;
    repeat (2) @(posedge clk);
    #1 resetn = 1'b1;
  endtask

  task automatic push_cmd(input logic [31:0] w);
    staged.push_back(w);
  endtask

  // Queue edits happen here, away from the buffer and monitor steps
  task automatic setup_slot();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_for(input int what, input int limit, input string desc);
    int n;
    n = 0;
    while (!cond_met(what) && n < limit) begin
      @(posedge clk);
      #2; // Registered outputs settled, monitor not due yet
      n++;
    end
    if (n >= limit) begin
      $display("Timed out at %0t waiting for %s", $time, desc);
      errors++;
    end
  endtask

  task automatic check_val(input string sig, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, sig, got, exp);
      errors++;
    end
  endtask

  task automatic start_test();
    err_before = errors + dut.chk.fail_cnt;
    apply_reset();
    setup_slot();
  endtask

  task automatic end_test(input string name);
    repeat (20) @(posedge clk);
    tests++;
    if (errors + dut.chk.fail_cnt != err_before) begin
      tests_failed++;
      $display("test %0d %s: FAIL", tests, name);
    end else begin
      $display("test %0d %s: ok", tests, name);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin
    logic [15:0]        codes[8];
    logic signed [15:0] cal;
    resetn    = 1'b0;
    cmd_word  = '0;
    cmd_empty = 1'b1;
    pop_seen  = 1'b0;
    bit_cnt   = 0;

    // Eight channels, zero calibration, ldac at the end
    start_test();
    push_cmd(make_cmd(3'd2, 1'b0, 1'b1, 25'd1000));
    for (int i = 0; i < 8; i++) begin
      codes[i] = pick_code();
      exp_q.push_back(frame_of(i[2:0], codes[i]));
    end
    for (int i = 0; i < 4; i++) push_cmd({codes[2*i+1], codes[2*i]}); // Odd channel high
    wait_for(5, LONG_LIMIT, "ldac pulse");
    repeat (40) @(posedge clk); // Room for a stray second pulse
    #2;
    check_val("ldac pulses", ldac_cnt, 1);
    check_val("frames before ldac", frames_at_ldac, 8);
    check_val("frames left", exp_q.size(), 0);
    check_val("words left", cmd_q.size(), 0);
    check_val("flags", flags, 0);
    end_test("dac_wr all channels");

    // Calibrated single channel
    start_test();
    cal      = $signed(rand_bits(12)) - 16'sd2048;
    codes[3] = pick_code();
    push_cmd(make_cmd(3'd1, 1'b0, 1'b0, {6'd0, 3'd3, cal}));
    push_cmd(make_cmd(3'd3, 1'b0, 1'b0, {6'd0, 3'd3, codes[3]}));
    exp_q.push_back(frame_of(3'd3, codes[3] + cal));
    wait_for(6, SHORT_LIMIT, "calibrated frame");
    check_val("words left", cmd_q.size(), 0);
    check_val("flags", flags, 0);
    end_test("set_cal then dac_wr_ch");

    // Calibration out of range
    start_test();
    push_cmd(make_cmd(3'd1, 1'b0, 1'b0, {6'd0, 3'd5, 16'd5000}));
    push_cmd(make_cmd(3'd3, 1'b0, 1'b0, {6'd0, 3'd5, pick_code()}));
    wait_for(2, SHORT_LIMIT, "cal_oob");
    repeat (100) @(posedge clk);
    #2;
    check_val("frames", frames_seen, 0);
    check_val("flags", flags, 5'b00100);
    end_test("cal out of range");

    start_test();
    push_cmd(make_cmd(3'd6, 1'b0, 1'b0, 25'd0));
    wait_for(4, SHORT_LIMIT, "bad_cmd");
    check_val("flags", flags, 5'b10000);
    end_test("bad opcode");

    start_test();
    push_cmd(make_cmd(3'd3, 1'b0, 1'b0, {6'd0, 3'd1, 16'hffff}));
    wait_for(1, SHORT_LIMIT, "dac_val_oob");
    check_val("frames", frames_seen, 0);
    check_val("flags", flags, 5'b00010);
    end_test("dac code ffff");

    // Continue bit with nothing behind it
    start_test();
    push_cmd(make_cmd(3'd0, 1'b1, 1'b0, 25'd5));
    wait_for(3, SHORT_LIMIT, "cmd_buf_underflow");
    check_val("flags", flags, 5'b01000);
    end_test("buffer underflow");

    // Delay far shorter than eight frames
    start_test();
    push_cmd(make_cmd(3'd2, 1'b0, 1'b0, 25'd10));
    for (int i = 0; i < 4; i++) push_cmd({pick_code(), pick_code()});
    wait_for(0, SHORT_LIMIT, "delay_too_short");
    check_val("flags", flags, 5'b00001);
    end_test("delay too short");

    errors = errors + dut.chk.fail_cnt;
    $display("%0d tests, %0d failed, %0d errors", tests, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(RUN_CYCLES * 8);
    $display("Watchdog expired, the tests did not finish in time");
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/dac_ctrl_chk.sv
`default_nettype none

module dac_ctrl_chk (
  input wire       clk,
  input wire       resetn,
  input wire       n_cs,
  input wire       ldac,
  input wire [4:0] flags // bad_cmd, underflow, cal_oob, val_oob, delay_too_short
);

  timeunit 1ns;
  timeprecision 100ps;

  int         fail_cnt = 0; // Read by the testbench
  logic [5:0] low_cnt;      // Length of the current n_cs low run

  always_ff @(posedge clk) begin
    if (!resetn) begin
      low_cnt <= '0;
    end else if (!n_cs) begin
      low_cnt <= low_cnt + 1'b1;
    end else begin
      low_cnt <= '0;
    end
  end

  //////////////////////////////
  // SPI framing
  //////////////////////////////

  // Full frame unless an error cut it
  a_frame_len: assert property (@(posedge clk) disable iff (!resetn)
    $rose(n_cs) |-> (low_cnt == 6'd24) || (flags != '0))
  else begin
    $error("n_cs low run of %0d cycles", low_cnt);
    fail_cnt++;
  end

  a_ldac_idle: assert property (@(posedge clk) disable iff (!resetn)
    !(ldac && !n_cs))
  else begin
    $error("ldac high during an SPI frame");
    fail_cnt++;
  end

  //////////////////////////////
  // Error flags
  //////////////////////////////

  a_sticky: assert property (@(posedge clk) disable iff (!resetn)
    ((flags | ~$past(flags)) == 5'h1f)) // Every flag set last cycle still set
  else begin
    $error("error flag cleared without reset");
    fail_cnt++;
  end

  a_dead: assert property (@(posedge clk) disable iff (!resetn)
    (flags != '0) |-> n_cs)
  else begin
    $error("n_cs low after an error flag");
    fail_cnt++;
  end

endmodule

`default_nettype wire

// File: hw/dac_ctrl_top.sv
`default_nettype none

module dac_ctrl_top (
  input  wire        clk,
  input  wire        resetn,
  // Show-ahead command buffer
  input  wire [31:0] cmd_word,
  input  wire        cmd_empty,
  output wire        cmd_rd_en,
  // DAC pins
  output wire        n_cs,
  output wire        mosi,
  output wire        ldac,
  // Sticky error flags
  output wire        bad_cmd,
  output wire        cmd_buf_underflow,
  output wire        cal_oob,
  output wire        dac_val_oob,
  output wire        delay_too_short
);

  dac_frame_if frame_bus ();
  cal_if       cal_bus ();

  // Value stage links
  logic               val_in_valid;
  dac_pkg::dac_code_t val_in_code;
  dac_pkg::cal_val_t  val_in_cal;
  logic               val_out_valid;
  dac_pkg::dac_code_t val_out_code;
  logic               val_out_oob;

  dac_seq_ctrl u_seq (
    .clk               (clk),
    .resetn            (resetn),
    .cmd_word          (cmd_word),
    .cmd_empty         (cmd_empty),
    .val_out_valid     (val_out_valid),
    .val_out_code      (val_out_code),
    .val_out_oob       (val_out_oob),
    .frame             (frame_bus.seq),
    .cal               (cal_bus.ctrl),
    .cmd_rd_en         (cmd_rd_en),
    .ldac              (ldac),
    .val_in_valid      (val_in_valid),
    .val_in_code       (val_in_code),
    .val_in_cal        (val_in_cal),
    .bad_cmd           (bad_cmd),
    .cmd_buf_underflow (cmd_buf_underflow),
    .cal_oob           (cal_oob),
    .dac_val_oob       (dac_val_oob),
    .delay_too_short   (delay_too_short)
  );

  cal_store u_cal (
    .clk    (clk),
    .resetn (resetn),
    .cal    (cal_bus.store)
  );

  dac_val_cal u_val (
    .clk       (clk),
    .resetn    (resetn),
    .in_valid  (val_in_valid),
    .in_code   (val_in_code),
    .in_cal    (val_in_cal),
    .out_valid (val_out_valid),
    .out_code  (val_out_code),
    .out_oob   (val_out_oob)
  );

  spi_frame_tx u_tx (
    .clk    (clk),
    .resetn (resetn),
    .frame  (frame_bus.tx),
    .n_cs   (n_cs),
    .mosi   (mosi)
  );

endmodule

`default_nettype wire

// File: hw/dac_seq_ctrl.sv
`default_nettype none

`include "dac_cfg.svh"

module dac_seq_ctrl (
  input  wire                       clk,
  input  wire                       resetn,
  input  wire [31:0]                cmd_word,
  input  wire                       cmd_empty,
  input  wire                       val_out_valid,
  input  wire dac_pkg::dac_code_t   val_out_code,
  input  wire                       val_out_oob,
  dac_frame_if.seq                  frame,
  cal_if.ctrl                       cal,
  output logic                      cmd_rd_en,
  output logic                      ldac,
  output logic                      val_in_valid,
  output dac_pkg::dac_code_t        val_in_code,
  output dac_pkg::cal_val_t         val_in_cal,
  output logic                      bad_cmd,
  output logic                      cmd_buf_underflow,
  output logic                      cal_oob,
  output logic                      dac_val_oob,
  output logic                      delay_too_short
);

  localparam int DLY_W = `DAC_DLY_MSB - `DAC_DLY_LSB + 1;

  // Per-channel steps inside WR_ALL / WR_CH
  typedef enum logic [1:0] {PH_FEED, PH_CALC, PH_SEND, PH_END} phase_e;

  dac_pkg::seq_state_e state;
  phase_e              phase;
  dac_pkg::opcode_e    op;
  dac_pkg::chan_t      chan_q;    // Channel in flight
  dac_pkg::dac_code_t  feed_code;
  logic [DLY_W-1:0]    timer;     // Command delay countdown
  logic [31:0]         pair_q;    // Current pair word, or the WR_CH command
  logic                cont_q;    // Continue bit of the running command
  logic                ldac_q;    // LDAC bit of the running command
  logic                op_known;
  logic                accept;
  logic                need_pair;
  logic                feed_ok;
  logic                cmd_end;
  logic                set_bad, set_unf, set_dly, set_voob, err_set;

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign op = dac_pkg::opcode_e'(cmd_word[`DAC_OP_MSB:`DAC_OP_LSB]);

  always_comb begin
    case (op)
      dac_pkg::NO_OP, dac_pkg::SET_CAL, dac_pkg::DAC_WR, dac_pkg::DAC_WR_CH: op_known = 1'b1;
      default: op_known = 1'b0;
    endcase
  end

  // Word still visible while the pop is in flight, so skip that cycle
  assign accept    = (state == dac_pkg::IDLE) && !cmd_empty && !cmd_rd_en;
  assign need_pair = (state == dac_pkg::WR_ALL) && !chan_q[0]; // Even channel opens a word
  assign feed_ok   = (phase == PH_FEED)
                     && (state == dac_pkg::WR_ALL || state == dac_pkg::WR_CH)
                     && (!need_pair || (!cmd_rd_en && !cmd_empty));

  // Low half for even channels, high half for odd
  assign feed_code = (state == dac_pkg::WR_CH) ? pair_q[`DAC_VAL_MSB:`DAC_VAL_LSB] :
                     chan_q[0]                 ? pair_q[31:16] :
                                                 cmd_word[`DAC_VAL_MSB:`DAC_VAL_LSB];

  assign cmd_end = !cmd_rd_en
                   && ((state == dac_pkg::DELAY && timer == '0)
                       || (state == dac_pkg::WR_ALL && phase == PH_END && timer == '0)
                       || (state == dac_pkg::WR_CH && phase == PH_END));

  // SET_CAL goes straight to the store
  assign cal.wr_en   = accept && (op == dac_pkg::SET_CAL);
  assign cal.wr_chan = cmd_word[`DAC_CH_MSB:`DAC_CH_LSB];
  assign cal.wr_val  = cmd_word[`DAC_VAL_MSB:`DAC_VAL_LSB];
  assign cal.rd_chan = chan_q;

  //////////////////////////////
  // Error sources
  //////////////////////////////

  assign set_bad  = accept && !op_known;
  assign set_unf  = (phase == PH_FEED && need_pair && !cmd_rd_en && cmd_empty) // Pair missing
                    || (cmd_end && cont_q && cmd_empty);                       // Nothing follows
  assign set_dly  = (state == dac_pkg::WR_ALL) && (phase != PH_END) && (timer == '0);
  assign set_voob = (feed_ok && feed_code == 16'hFFFF) || (val_out_valid && val_out_oob);
  assign err_set  = set_bad || set_unf || set_dly || set_voob || cal.oob;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      bad_cmd           <= 1'b0;
      cmd_buf_underflow <= 1'b0;
      cal_oob           <= 1'b0;
      dac_val_oob       <= 1'b0;
      delay_too_short   <= 1'b0;
    end else begin
      bad_cmd           <= bad_cmd | set_bad; // All sticky until reset
      cmd_buf_underflow <= cmd_buf_underflow | set_unf;
      cal_oob           <= cal_oob | cal.oob;
      dac_val_oob       <= dac_val_oob | set_voob;
      delay_too_short   <= delay_too_short | set_dly;
    end
  end

  //////////////////////////////
  // Sequencer FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state        <= dac_pkg::IDLE;
      phase        <= PH_FEED;
      chan_q       <= '0;
      timer        <= '0;
      cont_q       <= 1'b0;
      ldac_q       <= 1'b0;
      cmd_rd_en    <= 1'b0;
      ldac         <= 1'b0;
      val_in_valid <= 1'b0;
      frame.req    <= 1'b0;
    end else begin
      cmd_rd_en    <= 1'b0; // Single-cycle strobes
      ldac         <= 1'b0;
      val_in_valid <= 1'b0;
      // Delay only for NO_OP and DAC_WR, other commands reuse those bits
      if (accept) begin
        timer <= (op == dac_pkg::NO_OP || op == dac_pkg::DAC_WR) ?
                 cmd_word[`DAC_DLY_MSB:`DAC_DLY_LSB] : '0;
      end else if (timer != '0) begin
        timer <= timer - 1'b1;
      end
      if (err_set || state == dac_pkg::ERROR) begin
        state     <= dac_pkg::ERROR;
        frame.req <= 1'b0; // Cuts any frame in progress
      end else begin
        case (state)
          dac_pkg::IDLE: if (accept) begin
            cmd_rd_en <= 1'b1;
            cont_q    <= cmd_word[`DAC_CONT_BIT];
            ldac_q    <= cmd_word[`DAC_LDAC_BIT];
            phase     <= PH_FEED;
            case (op)
              dac_pkg::NO_OP:     state <= dac_pkg::DELAY;
              dac_pkg::DAC_WR: begin
                state  <= dac_pkg::WR_ALL;
                chan_q <= '0;
              end
              dac_pkg::DAC_WR_CH: begin
                state  <= dac_pkg::WR_CH;
                chan_q <= cmd_word[`DAC_CH_MSB:`DAC_CH_LSB];
              end
              default: ; // SET_CAL completes on the write strobe
            endcase
          end
          dac_pkg::WR_ALL, dac_pkg::WR_CH: begin
            case (phase)
              PH_FEED: if (feed_ok) begin
                val_in_valid <= 1'b1;
                cmd_rd_en    <= need_pair; // Pop the pair word
                phase        <= PH_CALC;
              end
              PH_CALC: if (val_out_valid) begin
                frame.req <= 1'b1;
                phase     <= PH_SEND;
              end
              PH_SEND: if (frame.ack) begin
                frame.req <= 1'b0;
                if (state == dac_pkg::WR_CH || chan_q == 3'd7) begin
                  phase <= PH_END;
                end else begin
                  chan_q <= chan_q + 3'd1;
                  phase  <= PH_FEED;
                end
              end
              default: ; // Wait for the timer
            endcase
          end
          default: ;
        endcase
        if (cmd_end) begin
          ldac  <= ldac_q;
          state <= dac_pkg::IDLE;
        end
      end
    end
  end

  // Payload, qualified by the strobes above
  always_ff @(posedge clk) begin
    if (accept || (feed_ok && need_pair)) begin
      pair_q <= cmd_word;
    end
    if (feed_ok) begin
      val_in_code <= feed_code;
      val_in_cal  <= cal.rd_val;
    end
    if (phase == PH_CALC && val_out_valid) begin
      frame.chan <= chan_q;
      frame.code <= val_out_code;
    end
  end

endmodule

`default_nettype wire

// File: hw/spi_frame_tx.sv
`default_nettype none

`include "dac_cfg.svh"

module spi_frame_tx (
  input  wire      clk,
  input  wire      resetn,
  dac_frame_if.tx  frame,
  output logic     n_cs,
  output logic     mosi
);

  localparam int CS_W  = $clog2(`DAC_NCS_HIGH + 1);
  localparam int BIT_W = $clog2(dac_pkg::FRAME_BITS);

  logic                           in_frame; // Request taken, no ack yet
  logic                           n_cs_q;
  logic [CS_W-1:0]                cs_cnt;   // High-time countdown
  logic [BIT_W-1:0]               bit_cnt;  // Bits left after the current one
  logic [dac_pkg::FRAME_BITS-1:0] shift_q;
  logic                           start;

  // No restart until the previous ack has fallen
  assign start = !in_frame && frame.req && !frame.ack;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      in_frame  <= 1'b0;
      n_cs_q    <= 1'b1;
      cs_cnt    <= '0;
      bit_cnt   <= '0;
      frame.ack <= 1'b0;
    end else if (!in_frame) begin
      if (start) begin
        in_frame <= 1'b1;
        cs_cnt   <= CS_W'(`DAC_NCS_HIGH - 1); // req rise cycle counts as one
      end
      if (frame.ack && !frame.req) begin
        frame.ack <= 1'b0;
      end
    end else if (!frame.req) begin
      in_frame <= 1'b0; // Aborted by the sequencer
      n_cs_q   <= 1'b1;
    end else if (n_cs_q) begin
      if (cs_cnt == CS_W'(1)) begin
        n_cs_q  <= 1'b0;
        bit_cnt <= BIT_W'(dac_pkg::FRAME_BITS - 1);
      end else begin
        cs_cnt <= cs_cnt - 1'b1;
      end
    end else if (bit_cnt == '0) begin
      n_cs_q    <= 1'b1; // Last bit done
      frame.ack <= 1'b1;
      in_frame  <= 1'b0;
    end else begin
      bit_cnt <= bit_cnt - 1'b1;
    end
  end

  // MSB first, next bit each cycle while n_cs is low
  always_ff @(posedge clk) begin
    if (start) begin
      shift_q <= {dac_pkg::SPI_CMD_WRITE, 1'b0, frame.chan, frame.code};
    end else if (in_frame && !n_cs_q && bit_cnt != '0) begin
      shift_q <= shift_q << 1;
    end
  end

  assign mosi = shift_q[dac_pkg::FRAME_BITS-1];
  assign n_cs = n_cs_q | !frame.req; // Goes high as soon as req is dropped

endmodule

`default_nettype wire

// File: hw/dac_val_cal.sv
`default_nettype none

module dac_val_cal (
  input  wire                     clk,
  input  wire                     resetn,
  input  wire                     in_valid,
  input  wire dac_pkg::dac_code_t in_code,
  input  wire dac_pkg::cal_val_t  in_cal,
  output logic                    out_valid,
  output dac_pkg::dac_code_t      out_code,
  output logic                    out_oob
);

  logic signed [15:0] in_signed; // Code minus midscale
  logic signed [16:0] sum;       // One guard bit for the add
  logic               sum_oob;

  // Flipping the MSB turns offset binary into two's complement
  assign in_signed = $signed(in_code ^ 16'h8000);
  assign sum       = {in_signed[15], in_signed} + {in_cal[15], in_cal};
  assign sum_oob   = (sum > 17'sd32767) || (sum < -17'sd32767);

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      out_valid <= 1'b0;
      out_oob   <= 1'b0;
    end else begin
      out_valid <= in_valid;
      out_oob   <= in_valid && sum_oob;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_code <= sum[15:0] ^ 16'h8000; // Back to offset binary
    end
  end

endmodule

`default_nettype wire

// File: hw/cal_store.sv
`default_nettype none

`include "dac_cfg.svh"

module cal_store (
  input  wire   clk,
  input  wire   resetn,
  cal_if.store  cal
);

  localparam int CAL_MAX = `DAC_CAL_MAX;

  dac_pkg::cal_val_t cal_q [8]; // One offset per channel
  logic              in_range;

  // Sign-extended compare against the symmetric bound
  assign in_range = (int'(cal.wr_val) <= CAL_MAX) && (int'(cal.wr_val) >= -CAL_MAX);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < 8; i++) begin
        cal_q[i] <= '0; // No offset until SET_CAL
      end
      cal.oob <= 1'b0;
    end else begin
      cal.oob <= cal.wr_en && !in_range; // Rejected write, register kept
      if (cal.wr_en && in_range) begin
        cal_q[cal.wr_chan] <= cal.wr_val;
      end
    end
  end

  assign cal.rd_val = cal_q[cal.rd_chan];

endmodule

`default_nettype wire

// File: hw/cal_if.sv
`default_nettype none

// Calibration register file access
interface cal_if;

  logic              wr_en;   // SET_CAL strobe
  dac_pkg::chan_t    wr_chan;
  dac_pkg::cal_val_t wr_val;
  dac_pkg::chan_t    rd_chan; // Channel being fed to the value stage
  dac_pkg::cal_val_t rd_val;  // Combinational read
  logic              oob;     // One-cycle pulse after a rejected write

  modport ctrl (output wr_en, wr_chan, wr_val, rd_chan, input rd_val, oob);

  modport store (input wr_en, wr_chan, wr_val, rd_chan, output rd_val, oob);

endinterface

`default_nettype wire

// File: hw/dac_frame_if.sv
`default_nettype none

// Four-phase frame request from sequencer to SPI transmitter
interface dac_frame_if;

  logic               req;  // Held until ack, early drop aborts the frame
  logic               ack;  // Frame ended, n_cs back high
  dac_pkg::chan_t     chan; // Stable while req is high
  dac_pkg::dac_code_t code; // Calibrated offset-binary code

  // Sequencer side
  modport seq (output req, chan, code, input ack);

  // Transmitter side
  modport tx (input req, chan, code, output ack);

endinterface

`default_nettype wire

// File: hw/dac_pkg.sv
`default_nettype none

package dac_pkg;

  //////////////////////////////
  // Command and FSM encodings
  //////////////////////////////

  // Command opcodes, anything else is a bad command
  typedef enum logic [2:0] {
    NO_OP     = 3'd0, // Timed delay
    SET_CAL   = 3'd1, // Load one channel calibration
    DAC_WR    = 3'd2, // All eight channels, four pair words follow
    DAC_WR_CH = 3'd3  // One channel, value in the command word
  } opcode_e;

  // Sequencer states
  typedef enum logic [2:0] {
    IDLE,   // Waiting on the command buffer
    DELAY,  // NO_OP timer running
    WR_ALL, // Eight-channel write
    WR_CH,  // Single-channel write
    ERROR   // Dead until reset
  } seq_state_e;

  //////////////////////////////
  // Value types
  //////////////////////////////

  typedef logic [15:0]        dac_code_t; // Offset binary, 8000 is midscale
  typedef logic signed [15:0] cal_val_t;  // Two's complement offset
  typedef logic [2:0]         chan_t;     // DAC channel 0 to 7

  // SPI frame layout
  localparam logic [3:0] SPI_CMD_WRITE = 4'b0001; // Write input register
  localparam int         FRAME_BITS    = 24;      // Cmd, zero, channel, code

endpackage

`default_nettype wire

// File: include/dac_cfg.svh
`ifndef DAC_CFG_SVH
`define DAC_CFG_SVH

// n_cs high time ahead of each SPI frame, in clk cycles (2 or more)
`define DAC_NCS_HIGH 4

// Calibration bound, applied as +/- on SET_CAL writes
`define DAC_CAL_MAX 4096

// Command word fields
`define DAC_OP_MSB   31 // Opcode
`define DAC_OP_LSB   29
`define DAC_CONT_BIT 27 // Another command must follow
`define DAC_LDAC_BIT 26 // Pulse LDAC at command end
`define DAC_DLY_MSB  24 // Delay, NO_OP and DAC_WR
`define DAC_DLY_LSB  0
`define DAC_CH_MSB   18 // Channel, SET_CAL and DAC_WR_CH
`define DAC_CH_LSB   16
`define DAC_VAL_MSB  15 // Value, SET_CAL and DAC_WR_CH
`define DAC_VAL_LSB  0

`endif
